// ==== vlog.f ====
common/axi_pkg.sv
common/ram_pkg.sv
common/ram_if.sv
hdl/burst_addr.sv
hdl/ram_pseudo_dual.sv
axi_write/axi_write_ctrl.sv
axi_read/axi_read_ctrl.sv
hdl/axi_ram_top.sv
testbench/tb_axi_ram.sv

// ==== Bender.yml ====
package:
  name: axi_ram

sources:
  - common/axi_pkg.sv
  - common/ram_pkg.sv
  - common/ram_if.sv
  - hdl/burst_addr.sv
  - hdl/ram_pseudo_dual.sv
  - axi_write/axi_write_ctrl.sv
  - axi_read/axi_read_ctrl.sv
  - hdl/axi_ram_top.sv
  - target: test
    files:
      - testbench/tb_axi_ram.sv

// ==== testbench/tb_axi_ram.sv ====
`timescale 1ns/1ps

module tb_axi_ram import axi_pkg::*; ();

    localparam int TIMEOUT_CYCLES = 200;

    logic                      S_AXI_ACLK;
    logic                      S_AXI_ARESETN;
    logic [AXI_ID_WIDTH-1:0]   S_AXI_AWID;
    logic [AXI_ADDR_WIDTH-1:0] S_AXI_AWADDR;
    logic [7:0]                S_AXI_AWLEN;
    logic [1:0]                S_AXI_AWBURST;
    logic                      S_AXI_AWVALID;
    logic                      S_AXI_AWREADY;
    logic [AXI_DATA_WIDTH-1:0] S_AXI_WDATA;
    logic [AXI_STRB_WIDTH-1:0] S_AXI_WSTRB;
    logic                      S_AXI_WLAST;
    logic                      S_AXI_WVALID;
    logic                      S_AXI_WREADY;
    logic [AXI_ID_WIDTH-1:0]   S_AXI_BID;
    logic [1:0]                S_AXI_BRESP;
    logic                      S_AXI_BVALID;
    logic                      S_AXI_BREADY;
    logic [AXI_ID_WIDTH-1:0]   S_AXI_ARID;
    logic [AXI_ADDR_WIDTH-1:0] S_AXI_ARADDR;
    logic [7:0]                S_AXI_ARLEN;
    logic [1:0]                S_AXI_ARBURST;
    logic                      S_AXI_ARVALID;
    logic                      S_AXI_ARREADY;
    logic [AXI_ID_WIDTH-1:0]   S_AXI_RID;
    logic [AXI_DATA_WIDTH-1:0] S_AXI_RDATA;
    logic [1:0]                S_AXI_RRESP;
    logic                      S_AXI_RLAST;
    logic                      S_AXI_RVALID;
    logic                      S_AXI_RREADY;

    logic [31:0] ref_mem [0:1023];   // expected RAM contents

    axi_ram_top dut0 (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .S_AXI_AWID    (S_AXI_AWID),
        .S_AXI_AWADDR  (S_AXI_AWADDR),
        .S_AXI_AWLEN   (S_AXI_AWLEN),
        .S_AXI_AWBURST (S_AXI_AWBURST),
        .S_AXI_AWVALID (S_AXI_AWVALID),
        .S_AXI_AWREADY (S_AXI_AWREADY),
        .S_AXI_WDATA   (S_AXI_WDATA),
        .S_AXI_WSTRB   (S_AXI_WSTRB),
        .S_AXI_WLAST   (S_AXI_WLAST),
        .S_AXI_WVALID  (S_AXI_WVALID),
        .S_AXI_WREADY  (S_AXI_WREADY),
        .S_AXI_BID     (S_AXI_BID),
        .S_AXI_BRESP   (S_AXI_BRESP),
        .S_AXI_BVALID  (S_AXI_BVALID),
        .S_AXI_BREADY  (S_AXI_BREADY),
        .S_AXI_ARID    (S_AXI_ARID),
        .S_AXI_ARADDR  (S_AXI_ARADDR),
        .S_AXI_ARLEN   (S_AXI_ARLEN),
        .S_AXI_ARBURST (S_AXI_ARBURST),
        .S_AXI_ARVALID (S_AXI_ARVALID),
        .S_AXI_ARREADY (S_AXI_ARREADY),
        .S_AXI_RID     (S_AXI_RID),
        .S_AXI_RDATA   (S_AXI_RDATA),
        .S_AXI_RRESP   (S_AXI_RRESP),
        .S_AXI_RLAST   (S_AXI_RLAST),
        .S_AXI_RVALID  (S_AXI_RVALID),
        .S_AXI_RREADY  (S_AXI_RREADY)
    );

    initial begin
        S_AXI_ACLK = 1'b0;
        forever #10 S_AXI_ACLK = ~S_AXI_ACLK;
    end

    task automatic flag_mismatch(input string what, input logic [31:0] exp,
                                 input logic [31:0] obs);
        $display("[ERROR] %0t ns: %s expected %h, observed %h", $time, what, exp, obs);
        $display("Errors found");
        $fatal(1, "%s check failed", what);
    endtask

    task automatic stop_on_timeout(input string what);
        $display("timed out at %0t ns while waiting for %s", $time, what);
        $display("Errors found");
        $fatal(1, "no response on %s", what);
    endtask

    // byte address of the following beat
    function automatic logic [15:0] next_beat_addr(input logic [15:0] a,
                                                   input logic [1:0] burst,
                                                   input logic [7:0] len);
        int unsigned block_bytes;
        int unsigned block_base;
        int unsigned offset;
        block_bytes = (int'(len) + 1) * 4;
        block_base  = a - (a % block_bytes);
        offset      = (a & 16'hfffc) - block_base;
        if (burst == FIXED) begin
            return a;
        end else if (burst == WRAP) begin
            return 16'(block_base + ((offset + 4) % block_bytes));
        end
        return (a & 16'hfffc) + 16'd4;   // INCR and the reserved code
    endfunction

    task automatic ref_write(input logic [15:0] a, input logic [31:0] d, input logic [3:0] strb);
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) begin
                ref_mem[a[11:2]][i*8 +: 8] = d[i*8 +: 8];   // upper bits alias
            end
        end
    endtask

    task automatic write_burst(input logic [3:0] id, input logic [15:0] addr,
                               input logic [7:0] len, input logic [1:0] burst,
                               input logic [3:0] strb, input bit stall);
        logic [15:0] a;
        logic [31:0] d;
        int          wait_cnt;
        int          stall_len;
        @(negedge S_AXI_ACLK);
        S_AXI_AWID    = id;
        S_AXI_AWADDR  = addr;
        S_AXI_AWLEN   = len;
        S_AXI_AWBURST = burst;
        S_AXI_AWVALID = 1'b1;
        wait_cnt = 0;
        while (!S_AXI_AWREADY) begin
            @(negedge S_AXI_ACLK);
            wait_cnt++;
            if (wait_cnt > TIMEOUT_CYCLES) stop_on_timeout("AWREADY");
        end
        @(negedge S_AXI_ACLK);
        S_AXI_AWVALID = 1'b0;
        a = addr;
        for (int beat = 0; beat <= int'(len); beat++) begin
            d = $urandom;
            S_AXI_WDATA  = d;
            S_AXI_WSTRB  = strb;
            S_AXI_WLAST  = (beat == int'(len));
            S_AXI_WVALID = 1'b1;
            wait_cnt = 0;
            while (!S_AXI_WREADY) begin
                @(negedge S_AXI_ACLK);
                wait_cnt++;
                if (wait_cnt > TIMEOUT_CYCLES) stop_on_timeout("WREADY");
            end
            @(negedge S_AXI_ACLK);   // beat taken at the edge just passed
            ref_write(a, d, strb);
            a = next_beat_addr(a, burst, len);
        end
        S_AXI_WVALID = 1'b0;
        S_AXI_WLAST  = 1'b0;
        wait_cnt = 0;
        while (!S_AXI_BVALID) begin
            @(negedge S_AXI_ACLK);
            wait_cnt++;
            if (wait_cnt > TIMEOUT_CYCLES) stop_on_timeout("BVALID");
        end
        if (stall) begin
            stall_len = $urandom_range(1, 6);
            repeat (stall_len) begin
                @(negedge S_AXI_ACLK);
                assert (S_AXI_BVALID === 1'b1)
                    else flag_mismatch("stalled BVALID", 1, S_AXI_BVALID);
                assert (S_AXI_BID === id)
                    else flag_mismatch("stalled BID", id, S_AXI_BID);
            end
        end
        assert (S_AXI_BID === id) else flag_mismatch("BID", id, S_AXI_BID);
        assert (S_AXI_BRESP === OKAY) else flag_mismatch("BRESP", OKAY, S_AXI_BRESP);
        S_AXI_BREADY = 1'b1;
        @(negedge S_AXI_ACLK);
        S_AXI_BREADY = 1'b0;
    endtask

    task automatic read_burst(input logic [3:0] id, input logic [15:0] addr,
                              input logic [7:0] len, input logic [1:0] burst, input bit stall);
        logic [15:0] a;
        logic [31:0] exp;
        logic [31:0] held_data;
        logic [3:0]  held_id;
        logic        held_last;
        int          wait_cnt;
        int          stall_len;
        @(negedge S_AXI_ACLK);
        S_AXI_ARID    = id;
        S_AXI_ARADDR  = addr;
        S_AXI_ARLEN   = len;
        S_AXI_ARBURST = burst;
        S_AXI_ARVALID = 1'b1;
        wait_cnt = 0;
        while (!S_AXI_ARREADY) begin
            @(negedge S_AXI_ACLK);
            wait_cnt++;
            if (wait_cnt > TIMEOUT_CYCLES) stop_on_timeout("ARREADY");
        end
        @(negedge S_AXI_ACLK);
        S_AXI_ARVALID = 1'b0;
        a = addr;
        for (int beat = 0; beat <= int'(len); beat++) begin
            exp = ref_mem[a[11:2]];
            wait_cnt = 0;
            while (!S_AXI_RVALID) begin
                @(negedge S_AXI_ACLK);
                wait_cnt++;
                if (wait_cnt > TIMEOUT_CYCLES) stop_on_timeout("RVALID");
            end
            if (stall) begin
                held_data = S_AXI_RDATA;
                held_id   = S_AXI_RID;
                held_last = S_AXI_RLAST;
                stall_len = $urandom_range(1, 6);
                repeat (stall_len) begin
                    @(negedge S_AXI_ACLK);
                    assert (S_AXI_RVALID === 1'b1)
                        else flag_mismatch("stalled RVALID", 1, S_AXI_RVALID);
                    assert (S_AXI_RDATA === held_data)
                        else flag_mismatch("stalled RDATA", held_data, S_AXI_RDATA);
                    assert (S_AXI_RID === held_id)
                        else flag_mismatch("stalled RID", held_id, S_AXI_RID);
                    assert (S_AXI_RLAST === held_last)
                        else flag_mismatch("stalled RLAST", held_last, S_AXI_RLAST);
                end
            end
            assert (S_AXI_RDATA === exp) else flag_mismatch("RDATA", exp, S_AXI_RDATA);
            assert (S_AXI_RID === id) else flag_mismatch("RID", id, S_AXI_RID);
            assert (S_AXI_RRESP === OKAY) else flag_mismatch("RRESP", OKAY, S_AXI_RRESP);
            assert (S_AXI_RLAST === (beat == int'(len)))
                else flag_mismatch("RLAST", (beat == int'(len)), S_AXI_RLAST);
            S_AXI_RREADY = 1'b1;
            @(negedge S_AXI_ACLK);
            S_AXI_RREADY = 1'b0;
            a = next_beat_addr(a, burst, len);
        end
    endtask

    task automatic check_reset_state();
        assert (S_AXI_AWREADY === 1'b1)
            else flag_mismatch("AWREADY after reset", 1, S_AXI_AWREADY);
        assert (S_AXI_ARREADY === 1'b1)
            else flag_mismatch("ARREADY after reset", 1, S_AXI_ARREADY);
        assert (S_AXI_WREADY === 1'b0)
            else flag_mismatch("WREADY after reset", 0, S_AXI_WREADY);
        assert (S_AXI_BVALID === 1'b0)
            else flag_mismatch("BVALID after reset", 0, S_AXI_BVALID);
        assert (S_AXI_RVALID === 1'b0)
            else flag_mismatch("RVALID after reset", 0, S_AXI_RVALID);
    endtask

    task automatic incr_round_trip();
        write_burst(4'h3, 16'h0100, 8'd7, INCR, 4'hf, 1'b0);
        read_burst(4'h5, 16'h0100, 8'd7, INCR, 1'b0);
    endtask

    task automatic byte_strobe_merge();
        write_burst(4'h1, 16'h0200, 8'd0, INCR, 4'hf, 1'b0);
        write_burst(4'h2, 16'h0200, 8'd0, INCR, 4'b0101, 1'b0);   // lanes 0 and 2 only
        read_burst(4'h7, 16'h0200, 8'd0, INCR, 1'b0);
    endtask

    task automatic wrap_block_fill();
        write_burst(4'h4, 16'h0308, 8'd3, WRAP, 4'hf, 1'b0);   // third word of 0x300 block
        read_burst(4'h6, 16'h0300, 8'd3, INCR, 1'b0);
    endtask

    task automatic fixed_overwrite();
        write_burst(4'h8, 16'h0400, 8'd3, FIXED, 4'hf, 1'b0);
        read_burst(4'hb, 16'h0400, 8'd3, FIXED, 1'b0);
    endtask

    task automatic stalled_handshakes();
        write_burst(4'h9, 16'h0600, 8'd7, INCR, 4'hf, 1'b1);
        read_burst(4'ha, 16'h0600, 8'd7, INCR, 1'b1);
        read_burst(4'hc, 16'h0610, 8'd7, WRAP, 1'b1);
    endtask

    initial begin
        void'($urandom(32'haf89));
        S_AXI_ARESETN = 1'b0;
        S_AXI_AWID    = '0;
        S_AXI_AWADDR  = '0;
        S_AXI_AWLEN   = '0;
        S_AXI_AWBURST = '0;
        S_AXI_AWVALID = 1'b0;
        S_AXI_WDATA   = '0;
        S_AXI_WSTRB   = '0;
        S_AXI_WLAST   = 1'b0;
        S_AXI_WVALID  = 1'b0;
        S_AXI_BREADY  = 1'b0;
        S_AXI_ARID    = '0;
        S_AXI_ARADDR  = '0;
        S_AXI_ARLEN   = '0;
        S_AXI_ARBURST = '0;
        S_AXI_ARVALID = 1'b0;
        S_AXI_RREADY  = 1'b0;
        repeat (10) @(negedge S_AXI_ACLK);
        S_AXI_ARESETN = 1'b1;
        check_reset_state();
        incr_round_trip();
        byte_strobe_merge();
        wrap_block_fill();
        fixed_overwrite();
        stalled_handshakes();
        $display("No errors");
        $finish;
    end

endmodule

// ==== hdl/axi_ram_top.sv ====
`timescale 1ns/1ps

module axi_ram_top import axi_pkg::*; (
    input  logic                      S_AXI_ACLK,
    input  logic                      S_AXI_ARESETN,

    // write address
    input  logic [AXI_ID_WIDTH-1:0]   S_AXI_AWID,
    input  logic [AXI_ADDR_WIDTH-1:0] S_AXI_AWADDR,
    input  logic [7:0]                S_AXI_AWLEN,
    input  logic [1:0]                S_AXI_AWBURST,
    input  logic                      S_AXI_AWVALID,
    output logic                      S_AXI_AWREADY,

    // write data
    input  logic [AXI_DATA_WIDTH-1:0] S_AXI_WDATA,
    input  logic [AXI_STRB_WIDTH-1:0] S_AXI_WSTRB,
    input  logic                      S_AXI_WLAST,    // unused, beats are counted
    input  logic                      S_AXI_WVALID,
    output logic                      S_AXI_WREADY,

    // write response
    output logic [AXI_ID_WIDTH-1:0]   S_AXI_BID,
    output logic [1:0]                S_AXI_BRESP,
    output logic                      S_AXI_BVALID,
    input  logic                      S_AXI_BREADY,

    // read address
    input  logic [AXI_ID_WIDTH-1:0]   S_AXI_ARID,
    input  logic [AXI_ADDR_WIDTH-1:0] S_AXI_ARADDR,
    input  logic [7:0]                S_AXI_ARLEN,
    input  logic [1:0]                S_AXI_ARBURST,
    input  logic                      S_AXI_ARVALID,
    output logic                      S_AXI_ARREADY,

    // read data
    output logic [AXI_ID_WIDTH-1:0]   S_AXI_RID,
    output logic [AXI_DATA_WIDTH-1:0] S_AXI_RDATA,
    output logic [1:0]                S_AXI_RRESP,
    output logic                      S_AXI_RLAST,
    output logic                      S_AXI_RVALID,
    input  logic                      S_AXI_RREADY
);

    ram_if ram_bus ();

    axi_write_ctrl wr0 (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .awid          (S_AXI_AWID),
        .awaddr        (S_AXI_AWADDR),
        .awlen         (S_AXI_AWLEN),
        .awburst       (burst_e'(S_AXI_AWBURST)),
        .awvalid       (S_AXI_AWVALID),
        .awready       (S_AXI_AWREADY),
        .wdata         (S_AXI_WDATA),
        .wstrb         (S_AXI_WSTRB),
        .wvalid        (S_AXI_WVALID),
        .wready        (S_AXI_WREADY),
        .bid           (S_AXI_BID),
        .bresp         (S_AXI_BRESP),
        .bvalid        (S_AXI_BVALID),
        .bready        (S_AXI_BREADY),
        .ram           (ram_bus.wr)
    );

    axi_read_ctrl rd0 (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .arid          (S_AXI_ARID),
        .araddr        (S_AXI_ARADDR),
        .arlen         (S_AXI_ARLEN),
        .arburst       (burst_e'(S_AXI_ARBURST)),
        .arvalid       (S_AXI_ARVALID),
        .arready       (S_AXI_ARREADY),
        .rid           (S_AXI_RID),
        .rdata         (S_AXI_RDATA),
        .rresp         (S_AXI_RRESP),
        .rlast         (S_AXI_RLAST),
        .rvalid        (S_AXI_RVALID),
        .rready        (S_AXI_RREADY),
        .ram           (ram_bus.rd)
    );

    ram_pseudo_dual mem0 (
        .S_AXI_ACLK (S_AXI_ACLK),
        .ram        (ram_bus.mem)
    );

endmodule

// ==== axi_read/axi_read_ctrl.sv ====
`timescale 1ns/1ps

module axi_read_ctrl import axi_pkg::*, ram_pkg::*; (
    input  logic      S_AXI_ACLK,
    input  logic      S_AXI_ARESETN,

    input  axi_id_t   arid,
    input  axi_addr_t araddr,
    input  axi_len_t  arlen,
    input  burst_e    arburst,
    input  logic      arvalid,
    output logic      arready,

    output axi_id_t   rid,
    output ram_word_t rdata,
    output resp_e     rresp,
    output logic      rlast,
    output logic      rvalid,
    input  logic      rready,

    ram_if.rd         ram
);

    // one RAM access per beat, FETCH issues it and CAPTURE takes the result
    typedef enum logic [1:0] {
        IDLE,
        FETCH,
        CAPTURE,
        SEND
    } state_e;

    state_e    state;
    axi_len_t  beat_cnt;

    axi_id_t   id_q;
    axi_addr_t addr_q;
    axi_len_t  len_q;
    burst_e    burst_q;
    axi_addr_t addr_next;

    // output register, stable while RREADY is low
    axi_id_t   rid_q;
    ram_word_t rdata_q;
    logic      rlast_q;

    logic      ar_fire;
    logic      r_fire;

    assign arready = (state == IDLE);
    assign rvalid  = (state == SEND);
    assign rid     = rid_q;
    assign rdata   = rdata_q;
    assign rlast   = rlast_q;
    assign rresp   = OKAY;

    assign ar_fire = arvalid && arready;
    assign r_fire  = rvalid && rready;

    burst_addr addr_gen (
        .addr      (addr_q),
        .burst     (burst_q),
        .len       (len_q),
        .next_addr (addr_next)
    );

    assign ram.re    = (state == FETCH);
    assign ram.raddr = addr_q[ADDR_LSB +: RAM_ADDR_WIDTH];

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            state    <= IDLE;
            beat_cnt <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (ar_fire) begin
                        beat_cnt <= '0;
                        state    <= FETCH;
                    end
                end
                FETCH: begin
                    state <= CAPTURE;
                end
                CAPTURE: begin
                    state <= SEND;
                end
                SEND: begin
                    if (r_fire) begin
                        if (rlast_q) begin
                            state <= IDLE;
                        end else begin
                            beat_cnt <= beat_cnt + 1'b1;
                            state    <= FETCH;   // next beat
                        end
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // burst parameters and address walk
    always_ff @(posedge S_AXI_ACLK) begin
        if (ar_fire) begin
            id_q    <= arid;
            addr_q  <= araddr;
            len_q   <= arlen;
            burst_q <= arburst;
        end else if (r_fire) begin
            addr_q <= addr_next;
        end
    end

    always_ff @(posedge S_AXI_ACLK) begin
        if (state == CAPTURE) begin
            rdata_q <= ram.rdata;
            rid_q   <= id_q;
            rlast_q <= (beat_cnt == len_q);
        end
    end

endmodule

// ==== axi_write/axi_write_ctrl.sv ====
`timescale 1ns/1ps

module axi_write_ctrl import axi_pkg::*, ram_pkg::*; (
    input  logic      S_AXI_ACLK,
    input  logic      S_AXI_ARESETN,

    input  axi_id_t   awid,
    input  axi_addr_t awaddr,
    input  axi_len_t  awlen,
    input  burst_e    awburst,
    input  logic      awvalid,
    output logic      awready,

    input  ram_word_t wdata,
    input  ram_strb_t wstrb,
    input  logic      wvalid,
    output logic      wready,

    output axi_id_t   bid,
    output resp_e     bresp,
    output logic      bvalid,
    input  logic      bready,

    ram_if.wr         ram
);

    typedef enum logic [1:0] {
        IDLE,
        DATA,
        RESP
    } state_e;

    state_e    state;
    axi_len_t  beat_cnt;

    // burst parameters held for the whole transaction
    axi_id_t   id_q;
    axi_addr_t addr_q;
    axi_len_t  len_q;
    burst_e    burst_q;
    axi_addr_t addr_next;

    logic      aw_fire;
    logic      w_fire;
    logic      b_fire;

    assign awready = (state == IDLE);
    assign wready  = (state == DATA);
    assign bvalid  = (state == RESP);
    assign bid     = id_q;
    assign bresp   = OKAY;

    assign aw_fire = awvalid && awready;
    assign w_fire  = wvalid && wready;
    assign b_fire  = bvalid && bready;

    burst_addr addr_gen (
        .addr      (addr_q),
        .burst     (burst_q),
        .len       (len_q),
        .next_addr (addr_next)
    );

    // each accepted beat goes straight into the RAM
    assign ram.we    = w_fire;
    assign ram.be    = wstrb;
    assign ram.wdata = wdata;
    assign ram.waddr = addr_q[ADDR_LSB +: RAM_ADDR_WIDTH];   // upper bits alias

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            state    <= IDLE;
            beat_cnt <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (aw_fire) begin
                        beat_cnt <= '0;
                        state    <= DATA;
                    end
                end
                DATA: begin
                    if (w_fire) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (beat_cnt == len_q) begin   // WLAST not trusted
                            state <= RESP;
                        end
                    end
                end
                RESP: begin
                    if (b_fire) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge S_AXI_ACLK) begin
        if (aw_fire) begin
            id_q    <= awid;
            addr_q  <= awaddr;
            len_q   <= awlen;
            burst_q <= awburst;
        end else if (w_fire) begin
            addr_q <= addr_next;
        end
    end

endmodule

// ==== hdl/ram_pseudo_dual.sv ====
`timescale 1ns/1ps

module ram_pseudo_dual import ram_pkg::*; (
    input logic S_AXI_ACLK,
    ram_if.mem  ram
);

    ram_word_t words [RAM_DEPTH];

    // byte masked write
    always_ff @(posedge S_AXI_ACLK) begin
        if (ram.we) begin
            for (int i = 0; i < $bits(ram_strb_t); i++) begin
                if (ram.be[i]) begin
                    words[ram.waddr][i*8 +: 8] <= ram.wdata[i*8 +: 8];
                end
            end
        end
    end

    // registered read, old data on a same-address collision
    always_ff @(posedge S_AXI_ACLK) begin
        if (ram.re) begin
            ram.rdata <= words[ram.raddr];
        end
    end

endmodule

// ==== hdl/burst_addr.sv ====
`timescale 1ns/1ps

module burst_addr import axi_pkg::*; (
    input  axi_addr_t addr,
    input  burst_e    burst,
    input  axi_len_t  len,
    output axi_addr_t next_addr
);

    logic [AXI_ADDR_WIDTH-1:ADDR_LSB] word;
    logic [AXI_ADDR_WIDTH-1:ADDR_LSB] word_inc;
    logic [AXI_ADDR_WIDTH-1:ADDR_LSB] wrap_mask;
    logic [AXI_ADDR_WIDTH-1:ADDR_LSB] word_wrap;

    assign word     = addr[AXI_ADDR_WIDTH-1:ADDR_LSB];
    assign word_inc = word + 1'b1;

    // legal wrap lengths are 2, 4, 8 or 16 beats, so len is already a low-bit mask
    assign wrap_mask = {{(AXI_ADDR_WIDTH - ADDR_LSB - 8){1'b0}}, len};

    // upper bits pinned to the block, low bits roll over inside it
    assign word_wrap = (word & ~wrap_mask) | (word_inc & wrap_mask);

    always_comb begin
        case (burst)
            FIXED: begin
                next_addr = addr;   // same location every beat
            end
            WRAP: begin
                next_addr = {word_wrap, {ADDR_LSB{1'b0}}};
            end
            default: begin   // INCR and the reserved code
                next_addr = {word_inc, {ADDR_LSB{1'b0}}};
            end
        endcase
    end

endmodule

// ==== common/ram_if.sv ====
`timescale 1ns/1ps

interface ram_if;

    // write port
    logic               we;      // single cycle strobe
    ram_pkg::ram_strb_t be;
    ram_pkg::ram_addr_t waddr;
    ram_pkg::ram_word_t wdata;

    // read port, rdata valid the cycle after re
    logic               re;
    ram_pkg::ram_addr_t raddr;
    ram_pkg::ram_word_t rdata;

    modport wr (
        output we, be, waddr, wdata
    );

    modport rd (
        output re, raddr,
        input  rdata
    );

    modport mem (
        input  we, be, waddr, wdata,
        input  re, raddr,
        output rdata
    );

endinterface

// ==== common/ram_pkg.sv ====
package ram_pkg;

    // word addressed storage, 4 KB in total
    localparam int RAM_ADDR_WIDTH = 10;
    localparam int RAM_DEPTH      = 1 << RAM_ADDR_WIDTH;

    typedef logic [RAM_ADDR_WIDTH-1:0] ram_addr_t;
    typedef logic [31:0]               ram_word_t;
    typedef logic [3:0]                ram_strb_t;   // one enable per byte lane

endpackage

// ==== common/axi_pkg.sv ====
package axi_pkg;

    // bus geometry
    localparam int AXI_ID_WIDTH   = 4;
    localparam int AXI_ADDR_WIDTH = 16;
    localparam int AXI_DATA_WIDTH = 32;
    localparam int AXI_STRB_WIDTH = AXI_DATA_WIDTH / 8;
    localparam int ADDR_LSB       = 2;   // byte offset bits within a word

    // AxBURST encodings
    typedef enum logic [1:0] {
        FIXED    = 2'b00,
        INCR     = 2'b01,
        WRAP     = 2'b10,
        RESERVED = 2'b11   // handled like INCR
    } burst_e;

    // xRESP encodings, only OKAY is ever returned
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } resp_e;

    typedef logic [AXI_ID_WIDTH-1:0]   axi_id_t;
    typedef logic [AXI_ADDR_WIDTH-1:0] axi_addr_t;
    typedef logic [7:0]                axi_len_t;   // beats minus one

endpackage
